// File: Bender.yml
package:
  name: prog_channels

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - prog_chan_pkg.sv
      - flash_req_if.sv
      - cfg_port_if.sv
      - prog_sequencer.sv
      - flash_cmd_builder.sv
      - chan_cfg_port.sv
      - prog_channels.sv
  - target: test
    include_dirs:
      - .
    files:
      - prog_channels_chk.sv
      - prog_channels_tb.sv

// File: cfg_port_if.sv
`timescale 1ns/10ps

interface cfg_port_if;

    logic progb_low;     // request to hold the channels in configuration reset
    logic stream_en;     // route the flash bitstream to c_din
    logic all_init_low;
    logic all_init_high;
    logic all_done;
    logic hold_done;     // reset pulse has met its minimum width

    modport sequencer (
        output progb_low,
        output stream_en,
        input  all_init_low,
        input  all_init_high,
        input  all_done,
        input  hold_done
    );

    modport port (
        input  progb_low,
        input  stream_en,
        output all_init_low,
        output all_init_high,
        output all_done,
        output hold_done
    );

endinterface

// File: chan_cfg_port.sv
`timescale 1ns/10ps
`include "prog_chan_config.svh"

module chan_cfg_port (
    input  logic                      clk,
    input  logic                      reset,
    input  prog_chan_pkg::chan_mask_t initb,
    input  prog_chan_pkg::chan_mask_t prog_done,
    input  logic                      bitstream,
    cfg_port_if.port                  cfg,
    output logic                      c_progb,
    output logic                      c_din
);
    import prog_chan_pkg::*;

    localparam hold_count_t HOLD_LAST = hold_count_t'(`PROG_HOLD_CYCLES - 1);

    chan_mask_t  initb_sync;
    chan_mask_t  done_sync;
    hold_count_t hold_cnt;
    logic        hold_flag;
    logic        count_en;
    logic        hold_last;

    // channel status lines come from another clock domain
    always_ff @(posedge clk) begin
        initb_sync <= initb;
        done_sync  <= prog_done;
    end

    assign cfg.all_init_low  = (initb_sync == '0);
    assign cfg.all_init_high = &initb_sync;
    assign cfg.all_done      = &done_sync;
    assign cfg.hold_done     = hold_flag;

    assign count_en  = cfg.progb_low && cfg.all_init_low && !hold_flag;
    assign hold_last = count_en && (hold_cnt == HOLD_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt  <= '0;
            hold_flag <= 1'b0;
        end else if (!cfg.progb_low) begin
            hold_cnt  <= '0;                 // ready for the next run
            hold_flag <= 1'b0;
        end else if (hold_last) begin
            hold_flag <= 1'b1;
        end else if (count_en) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            c_progb <= 1'b1;
            c_din   <= 1'b1;
        end else begin
            // release progb on the last hold cycle, not one later
            c_progb <= !(cfg.progb_low && !hold_flag && !hold_last);
            c_din   <= cfg.stream_en ? bitstream : 1'b1;
        end
    end

endmodule

// File: flash_cmd_builder.sv
`timescale 1ns/10ps
`include "prog_chan_config.svh"

module flash_cmd_builder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        async_mode,
    input  logic                        cbuf_mode,
    input  logic                        strg_mode,
    flash_req_if.builder                req,
    output logic                        store_flash_command,
    output logic                        send_write_command,
    output logic                        read_bitstream,
    output prog_chan_pkg::flash_cmd_t   flash_command,
    output prog_chan_pkg::flash_nbits_t flash_wr_nbits,
    output logic                        async_channels,
    output logic                        cbuf_channels
);
    import prog_chan_pkg::*;

    flash_addr_t  read_addr;
    flash_op_t    cmd_op;
    flash_addr_t  cmd_arg;
    flash_cmd_t   cmd_word;
    flash_nbits_t cmd_nbits;

    // image priority: async, cbuf, self trigger, then sync
    always_comb begin
        if (async_mode)
            read_addr = `ADDR_ASYNC;
        else if (cbuf_mode)
            read_addr = `ADDR_CBUF;
        else if (strg_mode)
            read_addr = `ADDR_STRG;
        else
            read_addr = `ADDR_SYNC;
    end

    always_comb begin
        cmd_op    = '0;
        cmd_arg   = '0;
        cmd_nbits = '0;
        case (req.cmd_sel)
            cmd_wren: begin
                cmd_op    = `OP_WRITE_ENABLE;
                cmd_nbits = `NBITS_WREN;
            end
            cmd_ext_set: begin
                cmd_op    = `OP_WRITE_EXT_ADDR;
                cmd_arg   = `EXT_ADDR_UPPER;
                cmd_nbits = `NBITS_EXT_ADDR;
            end
            cmd_ext_clr: begin
                cmd_op    = `OP_WRITE_EXT_ADDR; // register back to zero
                cmd_nbits = `NBITS_EXT_ADDR;
            end
            cmd_read: begin
                cmd_op  = `OP_READ;
                cmd_arg = read_addr;            // bit count comes from the flash side
            end
            default: begin
                cmd_op = '0;
            end
        endcase
    end

    assign cmd_word = {cmd_op, cmd_arg};

    always_ff @(posedge clk) begin
        if (reset) begin
            store_flash_command <= 1'b0;
            send_write_command  <= 1'b0;
            read_bitstream      <= 1'b0;
            async_channels      <= 1'b0;
            cbuf_channels       <= 1'b0;
        end else begin
            store_flash_command <= req.store_req;
            send_write_command  <= req.send_req;
            read_bitstream      <= req.read_req;
            if (req.store_req && (req.cmd_sel == cmd_read)) begin
                async_channels <= async_mode; // flags name the image actually read
                cbuf_channels  <= cbuf_mode;
            end
        end
    end

    always_ff @(posedge clk) begin
        flash_command  <= req.store_req ? cmd_word : '0;
        flash_wr_nbits <= req.send_req ? cmd_nbits : '0;
    end

endmodule

// File: flash_req_if.sv
`timescale 1ns/10ps

// command requests from the sequencer towards the flash interface
interface flash_req_if;
    import prog_chan_pkg::*;

    cmd_sel_t cmd_sel;   // which command word and bit count
    logic     store_req; // one cycle, store word in write buffer
    logic     send_req;  // held until end_write_command
    logic     read_req;  // held until end_bitstream

    modport sequencer (
        output cmd_sel,
        output store_req,
        output send_req,
        output read_req
    );

    modport builder (
        input  cmd_sel,
        input  store_req,
        input  send_req,
        input  read_req
    );

endinterface

// File: prog_chan_config.svh
`ifndef PROG_CHAN_CONFIG_SVH
`define PROG_CHAN_CONFIG_SVH

// extra cycles c_progb stays low once every channel shows init low
`define PROG_HOLD_CYCLES 16

`define OP_WRITE_ENABLE   8'h06    // write enable latch
`define OP_WRITE_EXT_ADDR 8'hC5    // write extended address register
`define OP_READ           8'h03    // plain read

`define NBITS_WREN     12'd7       // bits sent after the store, opcode only
`define NBITS_EXT_ADDR 12'd15      // opcode plus one register byte

// image start addresses, all inside the upper 16 MB of the flash
`define ADDR_SYNC  24'h00_0000
`define ADDR_ASYNC 24'h2E_0000
`define ADDR_CBUF  24'h5C_0000
`define ADDR_STRG  24'h8A_0000

`define EXT_ADDR_UPPER 24'h01_0000 // register byte 01 selects the upper half

`endif

// File: prog_chan_pkg.sv
package prog_chan_pkg;

    typedef logic [31:0] flash_cmd_t;   // word placed in the flash write buffer
    typedef logic [11:0] flash_nbits_t; // number of bits to send
    typedef logic [23:0] flash_addr_t;
    typedef logic [7:0]  flash_op_t;
    typedef logic [4:0]  chan_mask_t;   // one bit per channel FPGA
    typedef logic [3:0]  hold_count_t;

    // command selected for a store or a send
    typedef enum logic [2:0] {
        cmd_none,
        cmd_wren,
        cmd_ext_set,
        cmd_ext_clr,
        cmd_read
    } cmd_sel_t;

    typedef enum logic [3:0] {
        st_idle,
        st_store_wren1,
        st_send_wren1,
        st_store_ext1,
        st_send_ext1,
        st_store_read,
        st_start,         // progb low, waiting for all init lines low
        st_hold,
        st_wait_init,
        st_load,          // bitstream streaming to the channels
        st_wait_done,
        st_store_wren2,
        st_send_wren2,
        st_store_ext0,
        st_send_ext0,
        st_done
    } seq_state_t;

endpackage

// File: prog_channels.f
+incdir+.
prog_chan_pkg.sv
flash_req_if.sv
cfg_port_if.sv
prog_sequencer.sv
flash_cmd_builder.sv
chan_cfg_port.sv
prog_channels.sv
prog_channels_chk.sv
prog_channels_tb.sv

// File: prog_channels.sv
`timescale 1ns/10ps

module prog_channels (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        async_mode,
    input  logic                        cbuf_mode,
    input  logic                        strg_mode,
    input  logic                        prog_chan_start,
    input  logic                        bitstream,
    input  logic                        end_write_command,
    input  logic                        end_bitstream,
    input  prog_chan_pkg::chan_mask_t   initb,
    input  prog_chan_pkg::chan_mask_t   prog_done,
    output logic                        c_progb,
    output logic                        c_clk,
    output logic                        c_din,
    output logic                        store_flash_command,
    output logic                        send_write_command,
    output logic                        read_bitstream,
    output logic                        prog_chan_in_progress,
    output logic                        prog_chan_done,
    output logic                        async_channels,
    output logic                        cbuf_channels,
    output prog_chan_pkg::flash_cmd_t   flash_command,
    output prog_chan_pkg::flash_nbits_t flash_wr_nbits
);

    flash_req_if freq ();
    cfg_port_if  cfg ();

    assign c_clk = ~clk; // channels sample c_din mid-cycle

    prog_sequencer u_sequencer (
        .clk                   (clk),
        .reset                 (reset),
        .prog_chan_start       (prog_chan_start),
        .end_write_command     (end_write_command),
        .end_bitstream         (end_bitstream),
        .freq                  (freq.sequencer),
        .cfg                   (cfg.sequencer),
        .prog_chan_in_progress (prog_chan_in_progress),
        .prog_chan_done        (prog_chan_done)
    );

    flash_cmd_builder u_builder (
        .clk                 (clk),
        .reset               (reset),
        .async_mode          (async_mode),
        .cbuf_mode           (cbuf_mode),
        .strg_mode           (strg_mode),
        .req                 (freq.builder),
        .store_flash_command (store_flash_command),
        .send_write_command  (send_write_command),
        .read_bitstream      (read_bitstream),
        .flash_command       (flash_command),
        .flash_wr_nbits      (flash_wr_nbits),
        .async_channels      (async_channels),
        .cbuf_channels       (cbuf_channels)
    );

    chan_cfg_port u_cfg_port (
        .clk       (clk),
        .reset     (reset),
        .initb     (initb),
        .prog_done (prog_done),
        .bitstream (bitstream),
        .cfg       (cfg.port),
        .c_progb   (c_progb),
        .c_din     (c_din)
    );

endmodule

// File: prog_channels_chk.sv
`timescale 1ns/10ps

module prog_channels_chk (
    input logic clk,
    input logic reset,
    input logic store_flash_command,
    input logic prog_chan_done,
    input logic prog_chan_in_progress,
    input logic read_bitstream,
    input logic c_din
);

    int error_count = 0; // read by the testbench at the end of the run

    // each store is a single write buffer strobe
    store_single_cycle: assert property (@(posedge clk) disable iff (reset)
        store_flash_command |=> !store_flash_command)
    else begin
        error_count++;
        $error("store_flash_command high for two cycles in a row");
    end

    done_not_busy: assert property (@(posedge clk) disable iff (reset)
        !(prog_chan_done && prog_chan_in_progress))
    else begin
        error_count++;
        $error("prog_chan_done and prog_chan_in_progress high together");
    end

    din_idle_high: assert property (@(posedge clk) disable iff (reset)
        !read_bitstream |-> c_din)
    else begin
        error_count++;
        $error("c_din low while no bitstream is read");
    end

endmodule

// File: prog_channels_tb.sv
`timescale 1ns/10ps
`include "prog_chan_config.svh"

module prog_channels_tb;
    import prog_chan_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 10;
    localparam int N_RUNS       = 4;
    localparam int RUN_CYCLES   = 400; // upper bound for one full load
    localparam int STREAM_BITS  = 64;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_RUNS * RUN_CYCLES;

    logic         clk;
    logic         reset;
    logic         async_mode;
    logic         cbuf_mode;
    logic         strg_mode;
    logic         prog_chan_start;
    logic         bitstream;
    logic         end_write_command;
    logic         end_bitstream;
    chan_mask_t   initb;
    chan_mask_t   prog_done;
    logic         c_progb;
    logic         c_clk;
    logic         c_din;
    logic         store_flash_command;
    logic         send_write_command;
    logic         read_bitstream;
    logic         prog_chan_in_progress;
    logic         prog_chan_done;
    logic         async_channels;
    logic         cbuf_channels;
    flash_cmd_t   flash_command;
    flash_nbits_t flash_wr_nbits;

    flash_cmd_t   cmd_log[$];   // every stored command word of the current run
    flash_nbits_t nbits_log[$]; // every send bit count of the current run
    logic         read_seen;
    string        cur_test;

    prog_channels UUT (.*);

    bind prog_channels prog_channels_chk u_chk (
        .clk                   (clk),
        .reset                 (reset),
        .store_flash_command   (store_flash_command),
        .prog_chan_done        (prog_chan_done),
        .prog_chan_in_progress (prog_chan_in_progress),
        .read_bitstream        (read_bitstream),
        .c_din                 (c_din)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_cmd(input string name, input flash_cmd_t exp, input flash_cmd_t act);
        if (exp !== act)
            stop_on_error($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_nbits(input string name, input flash_nbits_t exp,
                               input flash_nbits_t act);
        if (exp !== act)
            stop_on_error($sformatf("mismatch %s: expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_on_error($sformatf("mismatch %s: expected %b actual %b", name, exp, act));
    endtask

    task automatic watchdog();
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("timeout: the controller did not finish its loads in the allowed time");
    endtask

    // flash interface model, logs stores and sends and serves the bitstream
    task automatic flash_model();
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (store_flash_command) begin
                cmd_log.push_back(flash_command);
                if (flash_command[31:24] == `OP_READ)
                    read_seen = 1'b1;
                else if (read_seen && flash_command[31:24] == `OP_WRITE_ENABLE)
                    check_bit({cur_test, " all done before write enable"}, 1'b1, &prog_done);
            end
            if (send_write_command) begin
                nbits_log.push_back(flash_wr_nbits);
                delay = $urandom_range(9, 2);
                repeat (delay) @(posedge clk);
                #2 end_write_command = 1'b1;
                @(posedge clk);
                #2 end_write_command = 1'b0; // end is a one-cycle answer
            end
            if (read_bitstream) begin
                #1;
                repeat (STREAM_BITS) begin
                    bitstream = $urandom_range(1, 0);
                    @(posedge clk);
                    #2;
                end
                end_bitstream = 1'b1;
                @(posedge clk);
                #2 end_bitstream = 1'b0;
            end
        end
    endtask

    // channel FPGAs, init low while progb is low, done after the stream
    task automatic channel_model();
        int delay;
        int low_cycles;
        forever begin
            @(negedge c_progb);
            #2;
            prog_done  = '0;
            initb      = '0;
            low_cycles = 0;
            do begin
                @(posedge clk);
                #1;
                if (!c_progb)
                    low_cycles++;
            end while (!c_progb);
            check_bit({cur_test, " progb hold long enough"}, 1'b1,
                      low_cycles >= `PROG_HOLD_CYCLES);
            delay = $urandom_range(8, 1);
            repeat (delay) @(posedge clk);
            #2 initb = '1;
            @(posedge read_bitstream);
            @(negedge read_bitstream);
            delay = $urandom_range(6, 1);
            repeat (delay) @(posedge clk);
            #2 prog_done = '1;
        end
    endtask

    task automatic din_monitor();
        logic prev_bit;
        forever begin
            @(posedge clk);
            prev_bit = bitstream; // value the DUT registered at this edge
            #1;
            if (read_bitstream)
                check_bit({cur_test, " c_din follows bitstream"}, prev_bit, c_din);
        end
    endtask

    task automatic check_reset_values();
        cur_test = "reset values";
        check_bit("reset c_progb", 1'b1, c_progb);
        check_bit("reset c_din", 1'b1, c_din);
        check_bit("reset store", 1'b0, store_flash_command);
        check_bit("reset send", 1'b0, send_write_command);
        check_bit("reset read", 1'b0, read_bitstream);
        check_bit("reset in progress", 1'b0, prog_chan_in_progress);
        check_bit("reset done", 1'b0, prog_chan_done);
        check_bit("reset async flag", 1'b0, async_channels);
        check_bit("reset cbuf flag", 1'b0, cbuf_channels);
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            #1;
            check_bit("idle store", 1'b0, store_flash_command);
            check_bit("idle send", 1'b0, send_write_command);
            check_bit("c_clk in high clock phase", 1'b0, c_clk);
            #(CLK_PERIOD / 2);
            check_bit("c_clk in low clock phase", 1'b1, c_clk);
        end
    endtask

    task automatic run_image(input string name, input logic a, input logic c, input logic s,
                             input flash_addr_t addr);
        flash_cmd_t   exp_cmd[5];
        flash_nbits_t exp_nbits[4];
        int           i;
        exp_cmd[0]   = {`OP_WRITE_ENABLE, 24'h00_0000};
        exp_cmd[1]   = {`OP_WRITE_EXT_ADDR, 8'h01, 16'h0000}; // upper 16 MB
        exp_cmd[2]   = {`OP_READ, addr};
        exp_cmd[3]   = {`OP_WRITE_ENABLE, 24'h00_0000};
        exp_cmd[4]   = {`OP_WRITE_EXT_ADDR, 24'h00_0000};
        exp_nbits[0] = `NBITS_WREN;
        exp_nbits[1] = `NBITS_EXT_ADDR;
        exp_nbits[2] = `NBITS_WREN;
        exp_nbits[3] = `NBITS_EXT_ADDR;
        cur_test = name;
        cmd_log.delete();
        nbits_log.delete();
        read_seen = 1'b0;
        @(posedge clk);
        #2;
        async_mode      = a;
        cbuf_mode       = c;
        strg_mode       = s;
        prog_chan_start = 1'b1;
        @(posedge clk);
        #1 check_bit({name, " no store at first edge"}, 1'b0, store_flash_command);
        @(posedge clk);
        #1 check_bit({name, " store at second edge"}, 1'b1, store_flash_command);
        check_bit({name, " in progress with first store"}, 1'b1, prog_chan_in_progress);
        while (prog_chan_done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        if (cmd_log.size() != 5 || nbits_log.size() != 4)
            stop_on_error($sformatf("%s: flash saw %0d stores and %0d sends, wanted 5 and 4",
                                    name, cmd_log.size(), nbits_log.size()));
        for (i = 0; i < 5; i++)
            check_cmd($sformatf("%s command %0d", name, i), exp_cmd[i], cmd_log[i]);
        for (i = 0; i < 4; i++)
            check_nbits($sformatf("%s send %0d", name, i), exp_nbits[i], nbits_log[i]);
        check_bit({name, " async flag"}, a, async_channels);
        check_bit({name, " cbuf flag"}, c, cbuf_channels);
        repeat (4) begin
            @(posedge clk);
            #1 check_bit({name, " done held with start"}, 1'b1, prog_chan_done);
        end
        #1 prog_chan_start = 1'b0;
        repeat (2) @(posedge clk); // done state, then idle
        #1;
        check_bit({name, " done after start falls"}, 1'b0, prog_chan_done);
        check_bit({name, " in progress after start falls"}, 1'b0, prog_chan_in_progress);
    endtask

    initial begin
        void'($urandom(33974));
        clk               = 1'b0;
        reset             = 1'b1;
        async_mode        = 1'b0;
        cbuf_mode         = 1'b0;
        strg_mode         = 1'b0;
        prog_chan_start   = 1'b0;
        bitstream         = 1'b0;
        end_write_command = 1'b0;
        end_bitstream     = 1'b0;
        initb             = '1;
        prog_done         = '0;
        read_seen         = 1'b0;
        cur_test          = "startup";
        fork
            watchdog();
            flash_model();
            channel_model();
            din_monitor();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
        check_reset_values();
        run_image("sync image", 1'b0, 1'b0, 1'b0, `ADDR_SYNC);
        run_image("async over cbuf", 1'b1, 1'b1, 1'b0, `ADDR_ASYNC);
        run_image("cbuf image", 1'b0, 1'b1, 1'b0, `ADDR_CBUF);
        run_image("self trigger image", 1'b0, 1'b0, 1'b1, `ADDR_STRG);
        if (UUT.u_chk.error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display("assertion checker reported %0d failures", UUT.u_chk.error_count);
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: prog_sequencer.sv
`timescale 1ns/10ps

module prog_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                prog_chan_start,
    input  logic                end_write_command,
    input  logic                end_bitstream,
    flash_req_if.sequencer      freq,
    cfg_port_if.sequencer       cfg,
    output logic                prog_chan_in_progress,
    output logic                prog_chan_done
);
    import prog_chan_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state                 <= st_idle;
            prog_chan_in_progress <= 1'b0;
            prog_chan_done        <= 1'b0;
        end else begin
            state                 <= next_state;
            // registered so both line up with the builder outputs
            prog_chan_in_progress <= (state != st_idle) && (state != st_done);
            prog_chan_done        <= (state == st_done);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:        if (prog_chan_start) next_state = st_store_wren1;
            st_store_wren1: next_state = st_send_wren1;
            st_send_wren1:  if (end_write_command) next_state = st_store_ext1;
            st_store_ext1:  next_state = st_send_ext1;
            st_send_ext1:   if (end_write_command) next_state = st_store_read;
            st_store_read:  next_state = st_start;
            st_start:       if (cfg.all_init_low) next_state = st_hold;
            st_hold:        if (cfg.hold_done) next_state = st_wait_init;
            st_wait_init:   if (cfg.all_init_high) next_state = st_load;
            st_load:        if (end_bitstream) next_state = st_wait_done;
            st_wait_done:   if (cfg.all_done) next_state = st_store_wren2;
            st_store_wren2: next_state = st_send_wren2;
            st_send_wren2:  if (end_write_command) next_state = st_store_ext0;
            st_store_ext0:  next_state = st_send_ext0;
            st_send_ext0:   if (end_write_command) next_state = st_done;
            st_done:        if (!prog_chan_start) next_state = st_idle; // wait for start to fall
            default:        next_state = st_idle;
        endcase
    end

    // requests decode from the state, the held ones drop with their end signal
    always_comb begin
        freq.cmd_sel   = cmd_none;
        freq.store_req = 1'b0;
        freq.send_req  = 1'b0;
        freq.read_req  = 1'b0;
        cfg.progb_low  = 1'b0;
        cfg.stream_en  = 1'b0;
        case (state)
            st_store_wren1, st_store_wren2: begin
                freq.cmd_sel   = cmd_wren;
                freq.store_req = 1'b1;
            end
            st_send_wren1, st_send_wren2: begin
                freq.cmd_sel  = cmd_wren;
                freq.send_req = !end_write_command;
            end
            st_store_ext1: begin
                freq.cmd_sel   = cmd_ext_set;
                freq.store_req = 1'b1;
            end
            st_send_ext1: begin
                freq.cmd_sel  = cmd_ext_set;
                freq.send_req = !end_write_command;
            end
            st_store_ext0: begin
                freq.cmd_sel   = cmd_ext_clr;
                freq.store_req = 1'b1;
            end
            st_send_ext0: begin
                freq.cmd_sel  = cmd_ext_clr;
                freq.send_req = !end_write_command;
            end
            st_store_read: begin
                freq.cmd_sel   = cmd_read;
                freq.store_req = 1'b1;
            end
            st_start, st_hold: begin
                cfg.progb_low = 1'b1;
            end
            st_load: begin
                freq.read_req = !end_bitstream;
                cfg.stream_en = !end_bitstream; // same edge as read_bitstream
            end
            default: begin
                freq.cmd_sel = cmd_none;
            end
        endcase
    end

endmodule
